// File: common/lpif_link_pkg.sv
// LPIF link package with lane geometry, link word layout and sync state type
package lpif_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // PHY lane geometry

  // Raw lane width
  localparam int LANE_W      = 40;
  // Lanes per link word
  localparam int LANE_COUNT  = 3;
  // Strobe at the bottom, marker at the top
  localparam int STB_BIT     = 0;
  localparam int MRK_BIT     = 39;
  // Payload sits in lane bits 1 to 38
  localparam int LANE_DATA_W = 38;

  ////////////////////////////////////////////////////////////////////////////
  // Link word layout

  localparam int WORD_W   = 89;
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 64;
  localparam int CRC_W    = 16;

  // Field positions, bit 0 upward
  localparam int VALID_POS     = 0;
  localparam int CRC_VALID_POS = 1;
  localparam int CRC_LSB       = 2;
  localparam int DVALID_POS    = 18;
  localparam int DATA_LSB      = 19;
  localparam int PROTID_LSB    = 83;
  localparam int STATE_LSB     = 85;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit sequencer states

  typedef enum logic [1:0] {
    sync_idle   = 2'd0,
    // Strobe only, payload zero
    sync_align  = 2'd1,
    // Strobe and marker with data
    sync_online = 2'd2
  } sync_state_t;

endpackage

// File: hdl/link_auto_sync.sv
// Link auto sync that delays tx and rx online levels and drives strobe and marker userbits
`timescale 1ns/100ps

module link_auto_sync (
  input  logic       clk_wr,
  input  logic       rst_n,
  input  logic       tx_online,
  input  logic       rx_online,
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,
  input  logic [7:0] delay_yz_value,
  output logic       tx_online_delay,
  output logic       tx_stb_userbit,
  output logic       tx_mrk_userbit,
  output logic       rx_online_delay
);

  lpif_link_pkg::sync_state_t tx_state;
  logic [7:0] tx_cnt;
  logic [8:0] rx_cnt;
  logic       rx_online_q;
  logic       rx_ready;
  logic       rx_rise;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit sequencer

  // Counter holds remaining align cycles minus one
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= lpif_link_pkg::sync_idle;
      tx_cnt   <= '0;
    end else if (!tx_online) begin
      // Drop straight back from any state
      tx_state <= lpif_link_pkg::sync_idle;
      tx_cnt   <= '0;
    end else begin
      case (tx_state)
        lpif_link_pkg::sync_idle: begin
          // Zero delay skips alignment entirely
          if (delay_xz_value == 8'd0) begin
            tx_state <= lpif_link_pkg::sync_online;
          end else begin
            tx_state <= lpif_link_pkg::sync_align;
            tx_cnt   <= delay_xz_value - 8'd1;
          end
        end
        lpif_link_pkg::sync_align: begin
          if (tx_cnt == 8'd0) begin
            tx_state <= lpif_link_pkg::sync_online;
          end else begin
            tx_cnt <= tx_cnt - 8'd1;
          end
        end
        lpif_link_pkg::sync_online: begin
          tx_state <= lpif_link_pkg::sync_online;
        end
        default: begin
          tx_state <= lpif_link_pkg::sync_idle;
        end
      endcase
    end
  end

  // Userbits straight from state
  assign tx_stb_userbit  = (tx_state != lpif_link_pkg::sync_idle);
  assign tx_mrk_userbit  = (tx_state == lpif_link_pkg::sync_online);
  assign tx_online_delay = (tx_state == lpif_link_pkg::sync_online);

  ////////////////////////////////////////////////////////////////////////////
  // Receive online delay

  assign rx_rise = rx_online & ~rx_online_q;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_online_q <= 1'b0;
      rx_cnt      <= '0;
      rx_ready    <= 1'b0;
    end else begin
      rx_online_q <= rx_online;
      if (!rx_online) begin
        rx_ready <= 1'b0;
      end else if (rx_rise) begin
        // Combined word alignment and skew delay
        rx_cnt   <= {1'b0, delay_x_value} + {1'b0, delay_yz_value};
        rx_ready <= 1'b0;
      end else if (!rx_ready) begin
        if (rx_cnt == 9'd0) begin
          rx_ready <= 1'b1;
        end else begin
          rx_cnt <= rx_cnt - 9'd1;
        end
      end
    end
  end

  // Falls in the same cycle as rx_online
  assign rx_online_delay = rx_online & rx_ready;

  // Marker only with strobe and a spent alignment count
  a_mrk_needs_stb: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    tx_mrk_userbit |-> tx_stb_userbit && (tx_cnt == 8'd0)
  );

endmodule

// File: hdl/lpif_link_top.sv
// LPIF link slave top wiring sync control, word pack and three lane PHY concat
`timescale 1ns/100ps

module lpif_link_top (
  input  logic                               clk_wr,
  input  logic                               rst_n,
  // Control
  input  logic                               tx_online,
  input  logic                               rx_online,
  input  logic [7:0]                         delay_x_value,
  input  logic [7:0]                         delay_xz_value,
  input  logic [7:0]                         delay_yz_value,
  // PHY lanes
  output logic [lpif_link_pkg::LANE_W-1:0]   tx_phy0,
  output logic [lpif_link_pkg::LANE_W-1:0]   tx_phy1,
  output logic [lpif_link_pkg::LANE_W-1:0]   tx_phy2,
  input  logic [lpif_link_pkg::LANE_W-1:0]   rx_phy0,
  input  logic [lpif_link_pkg::LANE_W-1:0]   rx_phy1,
  input  logic [lpif_link_pkg::LANE_W-1:0]   rx_phy2,
  // Upstream channel
  input  logic [lpif_link_pkg::STATE_W-1:0]  ustrm_state,
  input  logic [lpif_link_pkg::PROTID_W-1:0] ustrm_protid,
  input  logic [lpif_link_pkg::DATA_W-1:0]   ustrm_data,
  input  logic                               ustrm_dvalid,
  input  logic [lpif_link_pkg::CRC_W-1:0]    ustrm_crc,
  input  logic                               ustrm_crc_valid,
  input  logic                               ustrm_valid,
  // Downstream channel
  output logic [lpif_link_pkg::STATE_W-1:0]  dstrm_state,
  output logic [lpif_link_pkg::PROTID_W-1:0] dstrm_protid,
  output logic [lpif_link_pkg::DATA_W-1:0]   dstrm_data,
  output logic                               dstrm_dvalid,
  output logic [lpif_link_pkg::CRC_W-1:0]    dstrm_crc,
  output logic                               dstrm_crc_valid,
  output logic                               dstrm_valid
);

  logic [lpif_link_pkg::WORD_W-1:0] tx_word;
  logic [lpif_link_pkg::WORD_W-1:0] rx_word;
  logic                             rx_push;
  logic                             tx_stb_userbit;
  logic                             tx_mrk_userbit;
  logic                             rx_online_delay;

  ////////////////////////////////////////////////////////////////////////////
  // Online sequencing

  link_auto_sync u_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .tx_online_delay (),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Field mapping

  lpif_word_pack u_pack (
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .rx_word         (rx_word),
    .rx_push         (rx_push),
    .tx_word         (tx_word),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PHY lanes

  lane_tx_concat u_tx_lanes (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_word        (tx_word),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_phy0        (tx_phy0),
    .tx_phy1        (tx_phy1),
    .tx_phy2        (tx_phy2)
  );

  lane_rx_concat u_rx_lanes (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .rx_online_delay (rx_online_delay),
    .rx_word         (rx_word),
    .rx_push         (rx_push)
  );

endmodule

// File: hdl/lpif_word_pack.sv
// LPIF word pack, maps upstream fields into the link word and received word to downstream
`timescale 1ns/100ps

module lpif_word_pack (
  input  logic [lpif_link_pkg::STATE_W-1:0]  ustrm_state,
  input  logic [lpif_link_pkg::PROTID_W-1:0] ustrm_protid,
  input  logic [lpif_link_pkg::DATA_W-1:0]   ustrm_data,
  input  logic                               ustrm_dvalid,
  input  logic [lpif_link_pkg::CRC_W-1:0]    ustrm_crc,
  input  logic                               ustrm_crc_valid,
  input  logic                               ustrm_valid,
  input  logic [lpif_link_pkg::WORD_W-1:0]   rx_word,
  input  logic                               rx_push,
  output logic [lpif_link_pkg::WORD_W-1:0]   tx_word,
  output logic [lpif_link_pkg::STATE_W-1:0]  dstrm_state,
  output logic [lpif_link_pkg::PROTID_W-1:0] dstrm_protid,
  output logic [lpif_link_pkg::DATA_W-1:0]   dstrm_data,
  output logic                               dstrm_dvalid,
  output logic [lpif_link_pkg::CRC_W-1:0]    dstrm_crc,
  output logic                               dstrm_crc_valid,
  output logic                               dstrm_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // Upstream to link word

  // Flags low, state on top
  assign tx_word[lpif_link_pkg::VALID_POS]     = ustrm_valid;
  assign tx_word[lpif_link_pkg::CRC_VALID_POS] = ustrm_crc_valid;
  assign tx_word[lpif_link_pkg::CRC_LSB +: lpif_link_pkg::CRC_W] = ustrm_crc;
  assign tx_word[lpif_link_pkg::DVALID_POS]    = ustrm_dvalid;
  assign tx_word[lpif_link_pkg::DATA_LSB +: lpif_link_pkg::DATA_W] = ustrm_data;
  assign tx_word[lpif_link_pkg::PROTID_LSB +: lpif_link_pkg::PROTID_W] = ustrm_protid;
  assign tx_word[lpif_link_pkg::STATE_LSB +: lpif_link_pkg::STATE_W] = ustrm_state;

  ////////////////////////////////////////////////////////////////////////////
  // Received word to downstream

  // Values show the held word
  assign dstrm_crc    = rx_word[lpif_link_pkg::CRC_LSB +: lpif_link_pkg::CRC_W];
  assign dstrm_data   = rx_word[lpif_link_pkg::DATA_LSB +: lpif_link_pkg::DATA_W];
  assign dstrm_protid = rx_word[lpif_link_pkg::PROTID_LSB +: lpif_link_pkg::PROTID_W];
  assign dstrm_state  = rx_word[lpif_link_pkg::STATE_LSB +: lpif_link_pkg::STATE_W];

  // Flags only in a push cycle
  assign dstrm_valid     = rx_word[lpif_link_pkg::VALID_POS] & rx_push;
  assign dstrm_crc_valid = rx_word[lpif_link_pkg::CRC_VALID_POS] & rx_push;
  assign dstrm_dvalid    = rx_word[lpif_link_pkg::DVALID_POS] & rx_push;

endmodule

// File: lpif_link.f
common/lpif_link_pkg.sv
hdl/link_auto_sync.sv
hdl/lpif_word_pack.sv
phy_concat/lane_tx_concat.sv
phy_concat/lane_rx_concat.sv
hdl/lpif_link_top.sv
sim/lpif_link_tb.sv

// File: phy_concat/lane_rx_concat.sv
// Receive lane concat, qualifies lanes by strobe and marker and rebuilds the link word
`timescale 1ns/100ps

module lane_rx_concat (
  input  logic                              clk_wr,
  input  logic                              rst_n,
  input  logic [lpif_link_pkg::LANE_W-1:0]  rx_phy0,
  input  logic [lpif_link_pkg::LANE_W-1:0]  rx_phy1,
  input  logic [lpif_link_pkg::LANE_W-1:0]  rx_phy2,
  input  logic                              rx_online_delay,
  output logic [lpif_link_pkg::WORD_W-1:0]  rx_word,
  output logic                              rx_push
);

  localparam int PAY_W = lpif_link_pkg::LANE_COUNT * lpif_link_pkg::LANE_DATA_W;

  logic [PAY_W-1:0]                     pay;
  logic [lpif_link_pkg::LANE_COUNT-1:0] stb;
  logic [lpif_link_pkg::LANE_COUNT-1:0] mrk;
  logic                                 push;

  ////////////////////////////////////////////////////////////////////////////
  // Lane qualify

  assign stb = {rx_phy2[lpif_link_pkg::STB_BIT],
                rx_phy1[lpif_link_pkg::STB_BIT],
                rx_phy0[lpif_link_pkg::STB_BIT]};
  assign mrk = {rx_phy2[lpif_link_pkg::MRK_BIT],
                rx_phy1[lpif_link_pkg::MRK_BIT],
                rx_phy0[lpif_link_pkg::MRK_BIT]};

  // Data word on every lane, receive side online
  assign push = rx_online_delay & (&stb) & (&mrk);

  // Lane 0 holds the low bits
  assign pay = {rx_phy2[1 +: lpif_link_pkg::LANE_DATA_W],
                rx_phy1[1 +: lpif_link_pkg::LANE_DATA_W],
                rx_phy0[1 +: lpif_link_pkg::LANE_DATA_W]};

  ////////////////////////////////////////////////////////////////////////////
  // Word register

  // Holds last pushed word
  always_ff @(posedge clk_wr) begin
    if (push) begin
      rx_word <= pay[lpif_link_pkg::WORD_W-1:0];
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_push <= 1'b0;
    end else begin
      rx_push <= push;
    end
  end

  // Lanes in lockstep once receive is online
  a_stb_agree: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    rx_online_delay |-> ((stb == '0) || (&stb))
  );

endmodule

// File: phy_concat/lane_tx_concat.sv
// Transmit lane concat, splits the link word over three registered PHY lanes
`timescale 1ns/100ps

module lane_tx_concat (
  input  logic                              clk_wr,
  input  logic                              rst_n,
  input  logic [lpif_link_pkg::WORD_W-1:0]  tx_word,
  input  logic                              tx_stb_userbit,
  input  logic                              tx_mrk_userbit,
  output logic [lpif_link_pkg::LANE_W-1:0]  tx_phy0,
  output logic [lpif_link_pkg::LANE_W-1:0]  tx_phy1,
  output logic [lpif_link_pkg::LANE_W-1:0]  tx_phy2
);

  // Payload room over all lanes
  localparam int PAY_W = lpif_link_pkg::LANE_COUNT * lpif_link_pkg::LANE_DATA_W;

  logic [PAY_W-1:0]                 pay;
  logic [lpif_link_pkg::LANE_W-1:0] lane_d [lpif_link_pkg::LANE_COUNT];
  logic [lpif_link_pkg::LANE_W-1:0] lane_q [lpif_link_pkg::LANE_COUNT];

  // Upper bits of the last lane stay zero
  assign pay = {{(PAY_W - lpif_link_pkg::WORD_W){1'b0}}, tx_word};

  ////////////////////////////////////////////////////////////////////////////
  // Lane build

  always_comb begin
    for (int i = 0; i < lpif_link_pkg::LANE_COUNT; i++) begin
      lane_d[i] = '0;
      if (tx_stb_userbit) begin
        lane_d[i][lpif_link_pkg::STB_BIT] = 1'b1;
        lane_d[i][lpif_link_pkg::MRK_BIT] = tx_mrk_userbit;
        // Alignment words carry no payload
        if (tx_mrk_userbit) begin
          lane_d[i][1 +: lpif_link_pkg::LANE_DATA_W] =
            pay[i*lpif_link_pkg::LANE_DATA_W +: lpif_link_pkg::LANE_DATA_W];
        end
      end
    end
  end

  // One cycle launch register
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < lpif_link_pkg::LANE_COUNT; i++) begin
        lane_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < lpif_link_pkg::LANE_COUNT; i++) begin
        lane_q[i] <= lane_d[i];
      end
    end
  end

  assign tx_phy0 = lane_q[0];
  assign tx_phy1 = lane_q[1];
  assign tx_phy2 = lane_q[2];

  // Strobe low leaves quiet lanes next cycle
  a_quiet_lanes: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    !tx_stb_userbit |=> (tx_phy0 == '0) && (tx_phy1 == '0) && (tx_phy2 == '0)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LPIF link testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module lpif_link_tb \
  -Mdir obj_dir \
  -f lpif_link.f

./obj_dir/Vlpif_link_tb

// File: sim/lpif_link_tb.sv
// LPIF link testbench, random upstream traffic over lane loopback checked against a cycle model
`timescale 1ns/100ps

module lpif_link_tb;

  localparam int PAY_W = lpif_link_pkg::LANE_COUNT * lpif_link_pkg::LANE_DATA_W;

  // Phase lengths in clock cycles
  localparam int RESET_CYC   = 16;
  localparam int OFF_CYC     = 4;
  localparam int UP_CYC      = 70;
  localparam int RX_DROP_CYC = 12;
  localparam int RX_BACK_CYC = 50;
  localparam int TX_DROP_CYC = 8;
  localparam int TX_BACK_CYC = 40;
  localparam int ROUNDS      = 5;
  localparam int ROUND_CYC   = OFF_CYC + UP_CYC + RX_DROP_CYC + RX_BACK_CYC
                               + TX_DROP_CYC + TX_BACK_CYC;
  // 100 spare cycles on top of all phases
  localparam int LIMIT_NS    = (RESET_CYC + ROUNDS * ROUND_CYC + 100) * 20;

  logic                               clk_wr;
  logic                               rst_n;
  logic                               tx_online;
  logic                               rx_online;
  logic [7:0]                         delay_x_value;
  logic [7:0]                         delay_xz_value;
  logic [7:0]                         delay_yz_value;
  logic [lpif_link_pkg::LANE_W-1:0]   tx_phy0;
  logic [lpif_link_pkg::LANE_W-1:0]   tx_phy1;
  logic [lpif_link_pkg::LANE_W-1:0]   tx_phy2;
  logic [lpif_link_pkg::STATE_W-1:0]  ustrm_state;
  logic [lpif_link_pkg::PROTID_W-1:0] ustrm_protid;
  logic [lpif_link_pkg::DATA_W-1:0]   ustrm_data;
  logic                               ustrm_dvalid;
  logic [lpif_link_pkg::CRC_W-1:0]    ustrm_crc;
  logic                               ustrm_crc_valid;
  logic                               ustrm_valid;
  logic [lpif_link_pkg::STATE_W-1:0]  dstrm_state;
  logic [lpif_link_pkg::PROTID_W-1:0] dstrm_protid;
  logic [lpif_link_pkg::DATA_W-1:0]   dstrm_data;
  logic                               dstrm_dvalid;
  logic [lpif_link_pkg::CRC_W-1:0]    dstrm_crc;
  logic                               dstrm_crc_valid;
  logic                               dstrm_valid;

  // Reference model state
  logic [31:0]                      lfsr_state;
  lpif_link_pkg::sync_state_t       m_state;
  int                               m_left;
  logic [lpif_link_pkg::LANE_W-1:0] m_phy [lpif_link_pkg::LANE_COUNT];
  logic [lpif_link_pkg::WORD_W-1:0] m_sent_word;
  logic [lpif_link_pkg::WORD_W-1:0] m_word;
  logic                             m_word_ok;
  logic                             m_push;
  logic                             m_ready;
  int                               m_rx_seen;
  int                               m_rx_need;
  int                               push_count;

  always #10 clk_wr = ~clk_wr;

  // Lanes looped straight back by wire
  lpif_link_top DUT (
    .clk_wr (clk_wr), .rst_n (rst_n),
    .tx_online (tx_online), .rx_online (rx_online),
    .delay_x_value (delay_x_value), .delay_xz_value (delay_xz_value),
    .delay_yz_value (delay_yz_value),
    .tx_phy0 (tx_phy0), .tx_phy1 (tx_phy1), .tx_phy2 (tx_phy2),
    .rx_phy0 (tx_phy0), .rx_phy1 (tx_phy1), .rx_phy2 (tx_phy2),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data),
    .dstrm_dvalid (dstrm_dvalid), .dstrm_crc (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_step()};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic drive_fields();
    logic [63:0] r;
    r = rand_bits(lpif_link_pkg::STATE_W);
    ustrm_state = r[lpif_link_pkg::STATE_W-1:0];
    r = rand_bits(lpif_link_pkg::PROTID_W);
    ustrm_protid = r[lpif_link_pkg::PROTID_W-1:0];
    ustrm_data = rand_bits(lpif_link_pkg::DATA_W);
    r = rand_bits(lpif_link_pkg::CRC_W);
    ustrm_crc = r[lpif_link_pkg::CRC_W-1:0];
    r = rand_bits(3);
    ustrm_valid     = r[0];
    ustrm_crc_valid = r[1];
    ustrm_dvalid    = r[2];
  endtask

  // Delays kept within 0 to 15
  task automatic draw_delays();
    logic [63:0] r;
    r = rand_bits(12);
    delay_x_value  = {4'b0, r[3:0]};
    delay_xz_value = {4'b0, r[7:4]};
    delay_yz_value = {4'b0, r[11:8]};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  // Link word from the upstream fields, package layout
  function automatic logic [lpif_link_pkg::WORD_W-1:0] pack_fields();
    logic [lpif_link_pkg::WORD_W-1:0] w;
    w = '0;
    w[lpif_link_pkg::VALID_POS]     = ustrm_valid;
    w[lpif_link_pkg::CRC_VALID_POS] = ustrm_crc_valid;
    w[lpif_link_pkg::DVALID_POS]    = ustrm_dvalid;
    w[lpif_link_pkg::CRC_LSB +: lpif_link_pkg::CRC_W]       = ustrm_crc;
    w[lpif_link_pkg::DATA_LSB +: lpif_link_pkg::DATA_W]     = ustrm_data;
    w[lpif_link_pkg::PROTID_LSB +: lpif_link_pkg::PROTID_W] = ustrm_protid;
    w[lpif_link_pkg::STATE_LSB +: lpif_link_pkg::STATE_W]   = ustrm_state;
    return w;
  endfunction

  // Advance the model over the coming rising edge
  task automatic predict_edge();
    logic [lpif_link_pkg::WORD_W-1:0] word;
    logic [PAY_W-1:0]                 pay;
    logic                             stb;
    logic                             mrk;
    logic                             push_now;
    word = pack_fields();
    push_now = rx_online && m_ready;
    for (int i = 0; i < lpif_link_pkg::LANE_COUNT; i++) begin
      push_now = push_now && m_phy[i][lpif_link_pkg::STB_BIT]
                 && m_phy[i][lpif_link_pkg::MRK_BIT];
    end
    if (!rst_n) begin
      m_state   = lpif_link_pkg::sync_idle;
      m_left    = 0;
      m_push    = 1'b0;
      m_ready   = 1'b0;
      m_rx_seen = 0;
      for (int i = 0; i < lpif_link_pkg::LANE_COUNT; i++) begin
        m_phy[i] = '0;
      end
    end else begin
      // Second history stage, the word now on the lanes
      if (push_now) begin
        m_word     = m_sent_word;
        m_word_ok  = 1'b1;
        push_count = push_count + 1;
      end
      m_push = push_now;
      stb = (m_state != lpif_link_pkg::sync_idle);
      mrk = (m_state == lpif_link_pkg::sync_online);
      pay = '0;
      if (mrk) begin
        pay         = {{(PAY_W - lpif_link_pkg::WORD_W){1'b0}}, word};
        m_sent_word = word;
      end
      for (int i = 0; i < lpif_link_pkg::LANE_COUNT; i++) begin
        m_phy[i] = '0;
        if (stb) begin
          m_phy[i][lpif_link_pkg::STB_BIT] = 1'b1;
          m_phy[i][lpif_link_pkg::MRK_BIT] = mrk;
          m_phy[i][1 +: lpif_link_pkg::LANE_DATA_W] =
            pay[i*lpif_link_pkg::LANE_DATA_W +: lpif_link_pkg::LANE_DATA_W];
        end
      end
      // N alignment cycles for a delay of N
      if (!tx_online) begin
        m_state = lpif_link_pkg::sync_idle;
      end else if (m_state == lpif_link_pkg::sync_idle) begin
        m_left = int'(delay_xz_value);
        if (m_left == 0) begin
          m_state = lpif_link_pkg::sync_online;
        end else begin
          m_state = lpif_link_pkg::sync_align;
        end
      end else if (m_state == lpif_link_pkg::sync_align) begin
        m_left = m_left - 1;
        if (m_left == 0) begin
          m_state = lpif_link_pkg::sync_online;
        end
      end
      // Receive ready after x plus yz, counted from the load edge
      if (!rx_online) begin
        m_rx_seen = 0;
        m_ready   = 1'b0;
      end else begin
        if (m_rx_seen == 0) begin
          m_rx_need = int'(delay_x_value) + int'(delay_yz_value) + 2;
        end
        m_rx_seen = m_rx_seen + 1;
        m_ready   = (m_rx_seen >= m_rx_need);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checking

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    check_value("tx_phy0", 128'(m_phy[0]), 128'(tx_phy0));
    check_value("tx_phy1", 128'(m_phy[1]), 128'(tx_phy1));
    check_value("tx_phy2", 128'(m_phy[2]), 128'(tx_phy2));
    check_value("dstrm_valid", 128'(m_word[lpif_link_pkg::VALID_POS] & m_push),
                128'(dstrm_valid));
    check_value("dstrm_crc_valid", 128'(m_word[lpif_link_pkg::CRC_VALID_POS] & m_push),
                128'(dstrm_crc_valid));
    check_value("dstrm_dvalid", 128'(m_word[lpif_link_pkg::DVALID_POS] & m_push),
                128'(dstrm_dvalid));
    // Value fields exist only once a word has landed
    if (m_word_ok) begin
      check_value("dstrm_state",
                  128'(m_word[lpif_link_pkg::STATE_LSB +: lpif_link_pkg::STATE_W]),
                  128'(dstrm_state));
      check_value("dstrm_protid",
                  128'(m_word[lpif_link_pkg::PROTID_LSB +: lpif_link_pkg::PROTID_W]),
                  128'(dstrm_protid));
      check_value("dstrm_data",
                  128'(m_word[lpif_link_pkg::DATA_LSB +: lpif_link_pkg::DATA_W]),
                  128'(dstrm_data));
      check_value("dstrm_crc",
                  128'(m_word[lpif_link_pkg::CRC_LSB +: lpif_link_pkg::CRC_W]),
                  128'(dstrm_crc));
    end
  endtask

  // Outputs checked on the falling edge, then new inputs
  task automatic run_phase(input int cycles, input logic tx_on, input logic rx_on);
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk_wr);
      check_outputs();
      if (c == 0) begin
        draw_delays();
      end
      tx_online = tx_on;
      rx_online = rx_on;
      drive_fields();
      predict_edge();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    clk_wr          = 1'b0;
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = '0;
    delay_xz_value  = '0;
    delay_yz_value  = '0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    lfsr_state      = 32'h1e4a;
    m_state         = lpif_link_pkg::sync_idle;
    m_left          = 0;
    m_sent_word     = '0;
    m_word          = '0;
    m_word_ok       = 1'b0;
    m_push          = 1'b0;
    m_ready         = 1'b0;
    m_rx_seen       = 0;
    m_rx_need       = 0;
    push_count      = 0;
    for (int i = 0; i < lpif_link_pkg::LANE_COUNT; i++) begin
      m_phy[i] = '0;
    end
    // Reset held over 16 rising edges
    for (int c = 0; c < RESET_CYC; c++) begin
      @(negedge clk_wr);
      check_outputs();
      if (c == RESET_CYC - 1) begin
        rst_n = 1'b1;
      end
      drive_fields();
      predict_edge();
    end
    for (int r = 0; r < ROUNDS; r++) begin
      run_phase(OFF_CYC, 1'b0, 1'b0);
      run_phase(UP_CYC, 1'b1, 1'b1);
      run_phase(RX_DROP_CYC, 1'b1, 1'b0);
      run_phase(RX_BACK_CYC, 1'b1, 1'b1);
      run_phase(TX_DROP_CYC, 1'b0, 1'b1);
      run_phase(TX_BACK_CYC, 1'b1, 1'b1);
    end
    @(negedge clk_wr);
    check_outputs();
    if (push_count > 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "no word ever crossed the lane loopback");
    end
  end

  // Watchdog
  initial begin
    #(LIMIT_NS);
    $display("Test failed");
    $fatal(1, "watchdog expired before all test phases finished");
  end

endmodule
